// ==== sources.f ====
+incdir+tests
rtl/memTypes.sv
rtl/byteLane.sv
rtl/loadAligner.sv
rtl/accessController.sv
rtl/dataMemory.sv
tests/dataMemoryTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dataMemoryTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := tests/memModel.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the simulation prints the pass message
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/memModel.svh ====
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

byteT modelMem [MEM_DEPTH][LANES];                      // Expected bank contents

function automatic void modelClear();
    modelMem = '{default: '0};
endfunction

// Natural alignment per access size
function automatic logic modelAligned(input accessE size, input byteOffT off);
    case (size)
        ACC_BYTE:
            return 1'b1;
        ACC_HALF:
            return (off == 2'd0) || (off == 2'd2);
        ACC_WORD:
            return off == 2'd0;
        default:
            return 1'b0;
    endcase
endfunction

function automatic int accessBytes(input accessE size);
    case (size)
        ACC_HALF:
            return 2;
        ACC_WORD:
            return 4;
        default:
            return 1;
    endcase
endfunction

function automatic void modelStore(input memReqT req);
    byteOffT lane;
    if (!modelAligned(req.size, req.byteOff))
        return;                                         // Memory left untouched
    for (int i = 0; i < accessBytes(req.size); i++)
    begin
        lane = req.byteOff + byteOffT'(i);              // Little-endian with low byte first
        modelMem[req.wordAddr][lane] = byteT'(req.wrData >> (8 * i));
    end
endfunction

function automatic dataT modelLoad(input memReqT req);
    byteOffT lane;
    dataT    value;
    value = '0;
    for (int i = 0; i < accessBytes(req.size); i++)
    begin
        lane  = req.byteOff + byteOffT'(i);
        value = value | (dataT'(modelMem[req.wordAddr][lane]) << (8 * i));
    end
    // Word loads take no extension
    case (req.size)
        ACC_BYTE:
            if (!req.isUnsigned && value[7])
                value[31:8] = '1;
        ACC_HALF:
            if (!req.isUnsigned && value[15])
                value[31:16] = '1;
        default:
            ;
    endcase
    return value;
endfunction

`endif

// ==== tests/dataMemoryTb.sv ====
module dataMemoryTb;

    import memTypes::*;

    localparam int CLOCK_PERIOD    = 100;
    localparam int DRIVE_DELAY     = 10;                // After the rising edge
    localparam int RESET_CYCLES    = 10;
    localparam int ACK_LATENCY     = 2;
    localparam int ACK_LIMIT       = 8;
    localparam int WINDOW_BASE     = 64;
    localparam int WINDOW          = 16;                // Small so accesses collide
    localparam int CLEAR_TXNS      = MEM_DEPTH;
    localparam int SWEEP_TXNS      = 2 * WINDOW;
    localparam int PARTIAL_TXNS    = 4 * 12;
    localparam int SIGN_TXNS       = 4 * 13;
    localparam int MISALIGN_TXNS   = 5 * 3;
    localparam int RANDOM_TXNS     = 2000;
    localparam int TOTAL_TXNS      = CLEAR_TXNS + SWEEP_TXNS + PARTIAL_TXNS + SIGN_TXNS
                                     + MISALIGN_TXNS + RANDOM_TXNS;
    localparam int WATCHDOG_CYCLES = TOTAL_TXNS * 10 + 100;

    logic        i_clock = 1'b0;
    logic        i_rstN;
    logic        i_req;
    memReqT      i_request;
    logic        o_ack;
    dataT        o_rdData;
    logic        o_alignError;
    logic [31:0] rngState = 32'd92436;
    int          txnCount = 0;

    `include "memModel.svh"

    dataMemory dut_i
    (
        .i_clock      (i_clock),
        .i_rstN       (i_rstN),
        .i_req        (i_req),
        .i_request    (i_request),
        .o_ack        (o_ack),
        .o_rdData     (o_rdData),
        .o_alignError (o_alignError)
    );

    always
        #(CLOCK_PERIOD / 2) i_clock = ~i_clock;

    task automatic stopOnError();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic memReqT makeRequest(input wordAddrT addr, input byteOffT off,
                                           input accessE size, input logic isUnsigned,
                                           input logic write, input dataT data);
        memReqT req;
        req.wordAddr   = addr;
        req.byteOff    = off;
        req.size       = size;
        req.isUnsigned = isUnsigned;
        req.write      = write;
        req.wrData     = data;
        return req;
    endfunction

    function automatic memReqT randomRequest();
        logic [31:0] r;
        memReqT      req;
        r              = nextRandom();
        req.wordAddr   = wordAddrT'(WINDOW_BASE + int'(r % WINDOW));
        req.byteOff    = r[5:4];
        req.isUnsigned = r[12];
        req.write      = r[13];
        req.wrData     = nextRandom();
        case (r[9:8])
            2'd1:
                req.size = ACC_HALF;
            2'd2:
                req.size = ACC_WORD;
            default:
                req.size = ACC_BYTE;
        endcase
        return req;
    endfunction

    task automatic waitCycle();
        @(posedge i_clock);
        #DRIVE_DELAY;
    endtask

    task automatic checkResults(input memReqT req, input logic aligned, input dataT expData);
        assert (o_alignError == !aligned)
        else
        begin
            $display("FAIL o_alignError: got %h expected %h (addr %h off %h size %h)",
                     o_alignError, !aligned, req.wordAddr, req.byteOff, req.size);
            stopOnError();
        end
        if (aligned && !req.write)
        begin
            assert (o_rdData == expData)
            else
            begin
                $display("FAIL o_rdData: got %h expected %h (addr %h off %h size %h uns %h)",
                         o_rdData, expData, req.wordAddr, req.byteOff, req.size,
                         req.isUnsigned);
                stopOnError();
            end
        end
    endtask

    // One four-phase transaction with results compared while ack is high
    task automatic runAccess(input memReqT req);
        logic aligned;
        dataT expData;
        int   waited;
        int   holdCycles;
        aligned   = modelAligned(req.size, req.byteOff);
        expData   = '0;
        i_request = req;
        i_req     = 1'b1;
        waited    = 0;
        while (!o_ack && waited < ACK_LIMIT)
        begin
            waitCycle();
            waited++;
        end
        assert (o_ack)
        else
        begin
            $display("No ack within %0d cycles of the request", ACK_LIMIT);
            stopOnError();
        end
        assert (waited == ACK_LATENCY)
        else
        begin
            $display("Ack came %0d cycles after the request instead of %0d", waited, ACK_LATENCY);
            stopOnError();
        end
        if (aligned && req.write)
            modelStore(req);
        if (aligned && !req.write)
            expData = modelLoad(req);
        checkResults(req, aligned, expData);
        holdCycles = int'(nextRandom() % 3);            // Requester back-pressure
        repeat (holdCycles)
        begin
            waitCycle();
            assert (o_ack)
            else
            begin
                $display("Ack dropped while the request was still high");
                stopOnError();
            end
            checkResults(req, aligned, expData);        // Results held
        end
        i_req  = 1'b0;
        waited = 0;
        while (o_ack && waited < ACK_LIMIT)
        begin
            waitCycle();
            waited++;
        end
        assert (!o_ack && waited == 1)
        else
        begin
            $display("Ack did not drop one cycle after the request was released");
            stopOnError();
        end
        txnCount++;
    endtask

    task automatic storeWord(input wordAddrT addr, input dataT data);
        runAccess(makeRequest(addr, '0, ACC_WORD, 1'b0, 1'b1, data));
    endtask

    task automatic loadWord(input wordAddrT addr);
        runAccess(makeRequest(addr, '0, ACC_WORD, 1'b0, 1'b0, '0));
    endtask

    task automatic clearMemory();
        for (int a = 0; a < MEM_DEPTH; a++)
            storeWord(wordAddrT'(a), '0);
    endtask

    task automatic sweepWords();
        for (int a = 0; a < WINDOW; a++)
            storeWord(wordAddrT'(WINDOW_BASE + a), nextRandom());
        for (int a = 0; a < WINDOW; a++)
            loadWord(wordAddrT'(WINDOW_BASE + a));
    endtask

    task automatic partialStores();
        wordAddrT addr;
        for (int k = 0; k < 4; k++)
        begin
            addr = wordAddrT'(WINDOW_BASE + 5 * k);
            for (int off = 0; off < LANES; off++)
            begin
                runAccess(makeRequest(addr, byteOffT'(off), ACC_BYTE, 1'b0, 1'b1, nextRandom()));
                loadWord(addr);                         // Merged word
            end
            for (int off = 0; off < LANES; off += 2)
            begin
                runAccess(makeRequest(addr, byteOffT'(off), ACC_HALF, 1'b0, 1'b1, nextRandom()));
                loadWord(addr);
            end
        end
    endtask

    task automatic signedCheck(input dataT pattern);
        wordAddrT addr;
        addr = wordAddrT'(WINDOW_BASE + 7);
        storeWord(addr, pattern);
        for (int u = 0; u < 2; u++)
        begin
            for (int off = 0; off < LANES; off++)
                runAccess(makeRequest(addr, byteOffT'(off), ACC_BYTE, u[0], 1'b0, '0));
            for (int off = 0; off < LANES; off += 2)
                runAccess(makeRequest(addr, byteOffT'(off), ACC_HALF, u[0], 1'b0, '0));
        end
    endtask

    task automatic misalignedCase(input accessE size, input byteOffT off);
        wordAddrT addr;
        addr = wordAddrT'(WINDOW_BASE + 3);
        runAccess(makeRequest(addr, off, size, 1'b0, 1'b1, nextRandom()));
        loadWord(addr);                                 // Still the old word
        runAccess(makeRequest(addr, off, size, 1'b0, 1'b0, '0));
    endtask

    initial
    begin
        i_rstN    = 1'b0;
        i_req     = 1'b0;
        i_request = '0;
        modelClear();
        repeat (RESET_CYCLES) @(posedge i_clock);
        #DRIVE_DELAY;
        i_rstN = 1'b1;
        assert (!o_ack && !o_alignError)
        else
        begin
            $display("FAIL o_ack/o_alignError after reset: got %h/%h expected 0/0",
                     o_ack, o_alignError);
            stopOnError();
        end
        clearMemory();
        sweepWords();
        partialStores();
        signedCheck(32'h7F80_01FE);                     // Bytes with top bit set and clear
        signedCheck(32'h80FF_7F01);                     // Negative upper half
        signedCheck(nextRandom());
        signedCheck(nextRandom());
        misalignedCase(ACC_HALF, 2'd1);
        misalignedCase(ACC_HALF, 2'd3);
        misalignedCase(ACC_WORD, 2'd1);
        misalignedCase(ACC_WORD, 2'd2);
        misalignedCase(ACC_WORD, 2'd3);
        repeat (RANDOM_TXNS)
            runAccess(randomRequest());
        $display("%0d transactions completed", txnCount);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        stopOnError();
    end

endmodule

// ==== rtl/dataMemory.sv ====
module dataMemory
(
    input  logic             i_clock,      // Clock
    input  logic             i_rstN,       // Reset
    input  logic             i_req,        // Four-phase request
    input  memTypes::memReqT i_request,    // Access description
    output logic             o_ack,        // Four-phase acknowledge
    output memTypes::dataT   o_rdData,     // Load result
    output logic             o_alignError  // Misaligned access
);

    import memTypes::*;

    laneCmdT laneCmd   [LANES];
    byteT    laneBytes [LANES];
    memReqT  captured;

    accessController controller_i
    (
        .i_clock      (i_clock),
        .i_rstN       (i_rstN),
        .i_req        (i_req),
        .i_request    (i_request),
        .o_ack        (o_ack),
        .o_alignError (o_alignError),
        .o_laneCmd    (laneCmd),
        .o_captured   (captured)
    );

    for (genvar lane = 0; lane < LANES; lane++)
    begin : gLane
        byteLane bank_i
        (
            .i_clock   (i_clock),
            .i_laneCmd (laneCmd[lane]),
            .o_rdByte  (laneBytes[lane])
        );
    end

    loadAligner aligner_i
    (
        .i_laneBytes (laneBytes),
        .i_captured  (captured),
        .o_rdData    (o_rdData)
    );

endmodule

// ==== rtl/accessController.sv ====
module accessController
(
    input  logic              i_clock,                     // Clock
    input  logic              i_rstN,                      // Reset
    input  logic              i_req,                       // Four-phase request
    input  memTypes::memReqT  i_request,                   // Stable while i_req
    output logic              o_ack,                       // Four-phase acknowledge
    output logic              o_alignError,                // Misaligned access
    output memTypes::laneCmdT o_laneCmd [memTypes::LANES], // Per-bank commands
    output memTypes::memReqT  o_captured                   // Request in service
);

    import memTypes::*;

    ctrlStateE state;
    ctrlStateE nextState;
    memReqT    captured;
    logic      capture;
    logic      reqAligned;
    logic      inAccess;
    logic      laneEn;
    laneMaskT  wrMask;
    laneMaskT  laneEnVec;
    dataT      laneData;

    assign capture  = (state == ST_IDLE) && i_req;
    assign inAccess = (state == ST_ACCESS);
    assign laneEn   = inAccess && !o_alignError;         // Misaligned keeps banks idle

    // Natural alignment of the incoming request
    always_comb
    begin
        case (i_request.size)
            ACC_BYTE:
                reqAligned = 1'b1;
            ACC_HALF:
                reqAligned = !i_request.byteOff[0];
            ACC_WORD:
                reqAligned = (i_request.byteOff == '0);
            default:
                reqAligned = 1'b0;                       // Unused size code
        endcase
    end

    always_comb
    begin
        nextState = state;
        case (state)
            ST_IDLE:
                if (i_req)
                    nextState = ST_ACCESS;
            ST_ACCESS:
                nextState = ST_DONE;
            ST_DONE:
                if (!i_req)
                    nextState = ST_IDLE;
            default:
                nextState = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rstN)
        begin
            state        <= ST_IDLE;
            o_ack        <= 1'b0;
            o_alignError <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (capture)
                o_alignError <= !reqAligned;
            if (inAccess)
                o_ack <= 1'b1;
            else if ((state == ST_DONE) && !i_req)
                o_ack <= 1'b0;                           // Fourth phase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (capture)
            captured <= i_request;
    end

    // Lanes touched by a store
    always_comb
    begin
        case (captured.size)
            ACC_BYTE:
                wrMask = laneMaskT'(1) << captured.byteOff;
            ACC_HALF:
                wrMask = laneMaskT'(3) << captured.byteOff;
            ACC_WORD:
                wrMask = '1;
            default:
                wrMask = '0;
        endcase
    end

    // Low store bytes moved up to the addressed lanes
    assign laneData = captured.wrData << {captured.byteOff, 3'b000};

    always_comb
    begin
        for (int lane = 0; lane < LANES; lane++)
        begin
            o_laneCmd[lane].en     = laneEn;             // All lanes read
            o_laneCmd[lane].wr     = laneEn && captured.write && wrMask[lane];
            o_laneCmd[lane].addr   = captured.wordAddr;
            o_laneCmd[lane].wrByte = laneData[BYTE_W*lane +: BYTE_W];
            laneEnVec[lane]        = o_laneCmd[lane].en;
        end
    end

    assign o_captured = captured;

    ackNotIdle: assert property (@(posedge i_clock) disable iff (!i_rstN)
        (state == ST_IDLE) |-> !o_ack);

    // Banks are driven only in the cycle right after a capture
    enOnlyInAccess: assert property (@(posedge i_clock) disable iff (!i_rstN)
        (laneEnVec != '0) |-> $past(capture));

    // An errored access must not have reached the banks
    errorNoLanes: assert property (@(posedge i_clock) disable iff (!i_rstN)
        ($rose(o_ack) && o_alignError) |-> ($past(laneEnVec) == '0));

endmodule

// ==== rtl/loadAligner.sv ====
module loadAligner
(
    input  memTypes::byteT   i_laneBytes [memTypes::LANES], // Bank read bytes
    input  memTypes::memReqT i_captured,                   // Request in service
    output memTypes::dataT   o_rdData                      // Extended load result
);

    import memTypes::*;

    dataT        word;
    dataT        shifted;
    byteT        selByte;
    logic [15:0] selHalf;
    logic        fillBit;

    // Lane 0 is the least significant byte
    always_comb
    begin
        for (int lane = 0; lane < LANES; lane++)
            word[BYTE_W*lane +: BYTE_W] = i_laneBytes[lane];
    end

    assign shifted = word >> {i_captured.byteOff, 3'b000};
    assign selByte = shifted[7:0];
    assign selHalf = shifted[15:0];

    always_comb
    begin
        case (i_captured.size)
            ACC_BYTE:
            begin
                fillBit  = !i_captured.isUnsigned && selByte[7];
                o_rdData = {{24{fillBit}}, selByte};
            end
            ACC_HALF:
            begin
                fillBit  = !i_captured.isUnsigned && selHalf[15];
                o_rdData = {{16{fillBit}}, selHalf};
            end
            ACC_WORD:
            begin
                fillBit  = 1'b0;                   // Signedness ignored
                o_rdData = word;
            end
            default:
            begin
                fillBit  = 1'b0;
                o_rdData = word;
            end
        endcase
    end

endmodule

// ==== rtl/byteLane.sv ====
module byteLane
(
    input  logic              i_clock,   // Clock
    input  memTypes::laneCmdT i_laneCmd, // Command from the controller
    output memTypes::byteT    o_rdByte   // Registered read byte
);

    import memTypes::*;

    byteT mem [MEM_DEPTH];

    // Read before write so a store returns the old byte
    always_ff @(posedge i_clock)
    begin
        if (i_laneCmd.en)
        begin
            o_rdByte <= mem[i_laneCmd.addr];
            if (i_laneCmd.wr)
                mem[i_laneCmd.addr] <= i_laneCmd.wrByte;
        end
    end

    wrNeedsEn: assert property (@(posedge i_clock)
        i_laneCmd.wr |-> i_laneCmd.en);

endmodule

// ==== rtl/memTypes.sv ====
package memTypes;

    localparam int BYTE_W      = 8;
    localparam int LANES       = 4;                 // Byte lanes per word
    localparam int MEM_DEPTH   = 256;               // Words per bank
    localparam int WORD_ADDR_W = $clog2(MEM_DEPTH);
    localparam int BYTE_OFF_W  = $clog2(LANES);

    typedef logic [LANES*BYTE_W-1:0] dataT;
    typedef logic [BYTE_W-1:0]       byteT;
    typedef logic [WORD_ADDR_W-1:0]  wordAddrT;
    typedef logic [BYTE_OFF_W-1:0]   byteOffT;
    typedef logic [LANES-1:0]        laneMaskT;

    // Access width of a load or store
    typedef enum logic [1:0]
    {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2
    } accessE;

    typedef enum logic [1:0]
    {
        ST_IDLE   = 2'd0,                           // Waiting for i_req
        ST_ACCESS = 2'd1,                           // Banks read or written
        ST_DONE   = 2'd2                            // Ack held until i_req drops
    } ctrlStateE;

    // One access as issued by the requester
    typedef struct packed
    {
        wordAddrT wordAddr;
        byteOffT  byteOff;
        accessE   size;
        logic     isUnsigned;                       // Zero-extend on load
        logic     write;                            // Store when set
        dataT     wrData;
    } memReqT;

    // Command to a single byte bank
    typedef struct packed
    {
        logic     en;                               // Access this cycle
        logic     wr;                               // Write wrByte
        wordAddrT addr;
        byteT     wrByte;
    } laneCmdT;

endpackage
